// File: Makefile
# Verilator simulation of the fetch, decode and commit pipeline

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

obj_dir/Vtb_pipe_top: build.f *.sv *.svh
	verilator --binary --timing --assert -j 0 --top-module tb_pipe_top -f build.f

test: obj_dir/Vtb_pipe_top
	@out="$$(./obj_dir/Vtb_pipe_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+.
pipe_pkg.sv
fetch_fsm.sv
decode_stage.sv
commit_stage.sv
pipe_top.sv
tb_pipe_top.sv

// File: commit_stage.sv
// ID/commit register with in-order commit outputs and sticky halt/error status
`timescale 1ns/10ps
`include "pipe_settings.svh"

module commit_stage
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      id_valid,
  input  logic [`INST_WIDTH-1:0]    id_ir,
  input  logic [`PC_WIDTH-1:0]      id_npc,
  input  logic [`REG_IDX_WIDTH-1:0] id_dest_idx,
  input  logic                      id_halt,
  input  logic                      id_illegal,
  output logic                      commit_valid,
  output logic [`PC_WIDTH-1:0]      commit_npc,
  output logic [`INST_WIDTH-1:0]    commit_ir,
  output logic [`REG_IDX_WIDTH-1:0] commit_wr_idx,
  output logic                      commit_wr_en,
  output pipe_pkg::error_status_t   error_status,
  output logic                      halted
);

  import pipe_pkg::*;

  logic take;   // Instruction commits this edge

  assign take = id_valid && !halted;

  //////////////////////////////////////////////////
  // Commit control and sticky status

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      commit_valid <= 1'b0;
      commit_wr_en <= 1'b0;
      error_status <= NO_ERROR;
      halted       <= 1'b0;
    end
    else
    begin
      commit_valid <= take;
      commit_wr_en <= take && (id_dest_idx != `ZERO_REG);
      if (take && id_illegal)
      begin
        error_status <= HALTED_ON_ILLEGAL;
        halted       <= 1'b1;
      end
      else if (take && id_halt)
      begin
        error_status <= HALTED_ON_HALT;
        halted       <= 1'b1;
      end
    end
  end

  // Committed instruction payload
  always_ff @(posedge clock)
  begin
    if (take)
    begin
      commit_npc    <= id_npc;
      commit_ir     <= id_ir;
      commit_wr_idx <= id_dest_idx;
    end
  end

  // Checks
  a_no_commit_after_halt: assert property (@(posedge clock) disable iff (reset)
    halted |=> !commit_valid);

endmodule

// File: decode_stage.sv
// IF/ID register and decoder for destination register, halt and illegal flags
`timescale 1ns/10ps
`include "pipe_settings.svh"

module decode_stage
(
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     if_valid,
  input  logic [`INST_WIDTH-1:0]   if_ir,
  input  logic [`PC_WIDTH-1:0]     if_npc,
  output logic                     id_valid,
  output logic [`INST_WIDTH-1:0]   id_ir,
  output logic [`PC_WIDTH-1:0]     id_npc,
  output logic [`REG_IDX_WIDTH-1:0] id_dest_idx,
  output logic                     id_halt,
  output logic                     id_illegal
);

  import pipe_pkg::*;

  inst_word_t                 ir_q;
  logic [`PAL_FUNC_WIDTH-1:0] pal_func;
  logic [`REG_IDX_WIDTH-1:0]  dest_idx;
  logic                       is_halt;
  logic                       is_illegal;

  //////////////////////////////////////////////////
  // IF/ID register, never stalls

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      id_valid <= 1'b0;
      ir_q     <= `NOOP_INST;
    end
    else
    begin
      id_valid <= if_valid;
      ir_q     <= if_ir;
    end
  end

  always_ff @(posedge clock)
  begin
    id_npc <= if_npc;
  end

  //////////////////////////////////////////////////
  // Decode

  // PAL function spans everything below the opcode
  assign pal_func = {ir_q.mem_fmt.ra, ir_q.mem_fmt.rb, ir_q.mem_fmt.disp};

  always_comb
  begin
    dest_idx   = `ZERO_REG;
    is_halt    = 1'b0;
    is_illegal = 1'b0;
    case (ir_q.mem_fmt.opcode)
      `OP_INTA:
        dest_idx = ir_q.op_fmt.rc;
      `OP_LDQ:
        dest_idx = ir_q.mem_fmt.ra;
      `OP_STQ:
        dest_idx = `ZERO_REG;   // Nothing written back
      `OP_PAL:
      begin
        if (pal_func == `PAL_HALT)
          is_halt = 1'b1;
        else
          is_illegal = 1'b1;
      end
      default:
        is_illegal = 1'b1;      // Branches land here too
    endcase
  end

  assign id_ir       = ir_q;
  assign id_dest_idx = dest_idx;
  assign id_halt     = id_valid && is_halt;      // Empty slot flags nothing
  assign id_illegal  = id_valid && is_illegal;

  // Checks
  a_halt_xor_illegal: assert property (@(posedge clock) disable iff (reset)
    !(id_halt && id_illegal));

endmodule

// File: fetch_fsm.sv
// Fetch FSM with memory handshake, PC, held memory word and per-cycle instruction delivery
`timescale 1ns/10ps
`include "pipe_settings.svh"

module fetch_fsm
(
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   halted,             // Sticky, from commit
  input  logic [`TAG_WIDTH-1:0]  mem2proc_response,  // Accepted tag, 0 is a refusal
  input  logic [`TAG_WIDTH-1:0]  mem2proc_tag,
  input  logic [`MEM_WIDTH-1:0]  mem2proc_data,
  output pipe_pkg::bus_cmd_t     proc2mem_command,
  output logic [`PC_WIDTH-1:0]   proc2mem_addr,
  output logic                   if_valid,
  output logic [`INST_WIDTH-1:0] if_ir,
  output logic [`PC_WIDTH-1:0]   if_npc
);

  import pipe_pkg::*;

  localparam logic [`PC_WIDTH-1:0] pc_step = 4;

  fetch_state_t          state;
  fetch_state_t          next_state;
  logic [`PC_WIDTH-1:0]  pc;
  logic [`PC_WIDTH-1:0]  pc_plus4;
  logic [`TAG_WIDTH-1:0] held_tag;
  logic [`MEM_WIDTH-1:0] held_word;
  logic                  accepted;
  logic                  tag_match;

  assign accepted  = (state == REQUEST) && (proc2mem_command == BUS_LOAD) &&
                     (mem2proc_response != '0);
  assign tag_match = (state == WAIT) && (mem2proc_tag == held_tag);
  assign pc_plus4  = pc + pc_step;

  //////////////////////////////////////////////////
  // Next state

  always_comb
  begin
    next_state = state;
    if (halted)
      next_state = HALTED;   // Drop whatever is still in flight
    else
    begin
      case (state)
        REQUEST:
          if (accepted)
            next_state = WAIT;
        WAIT:
          if (tag_match)
            next_state = DELIVER;
        DELIVER:
          if (pc[2])
            next_state = REQUEST;  // High half sent, go for the next word
        HALTED:
          next_state = HALTED;     // Left only through reset
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Control registers and PC

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state            <= REQUEST;
      pc               <= '0;
      held_tag         <= '0;
      proc2mem_command <= BUS_NONE;
    end
    else
    begin
      state            <= next_state;
      // LOAD stays up until a nonzero response
      proc2mem_command <= (next_state == REQUEST) ? BUS_LOAD : BUS_NONE;
      if (accepted)
        held_tag <= mem2proc_response;
      if (if_valid)
        pc <= pc_plus4;
    end
  end

  // Returned memory word
  always_ff @(posedge clock)
  begin
    if (tag_match)
      held_word <= mem2proc_data;
  end

  //////////////////////////////////////////////////
  // Outputs

  assign proc2mem_addr = {pc[`PC_WIDTH-1:3], 3'b000};
  assign if_valid      = (state == DELIVER);
  assign if_ir         = pc[2] ? held_word[`MEM_WIDTH-1:`INST_WIDTH]
                               : held_word[`INST_WIDTH-1:0];
  assign if_npc        = pc_plus4;

  // Checks
  a_load_in_request: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD) |-> (state == REQUEST));

  a_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD) |-> (proc2mem_addr[2:0] == 3'b000));

  // Refused request comes back the next cycle, same word
  a_refused_repeat: assert property (@(posedge clock) disable iff (reset)
    ((proc2mem_command == BUS_LOAD) && (mem2proc_response == '0) && !halted)
      |=> ((proc2mem_command == BUS_LOAD) && $stable(proc2mem_addr)));

endmodule

// File: pipe_pkg.sv
// Package with the instruction word union and the bus, error and fetch state types
`include "pipe_settings.svh"

package pipe_pkg;

  // Memory format, also PAL with {ra, rb, disp} as function
  typedef struct packed {
    logic [`OP_WIDTH-1:0]      opcode;
    logic [`REG_IDX_WIDTH-1:0] ra;
    logic [`REG_IDX_WIDTH-1:0] rb;
    logic [15:0]               disp;
  } mem_fmt_t;

  // Operate format
  typedef struct packed {
    logic [`OP_WIDTH-1:0]      opcode;
    logic [`REG_IDX_WIDTH-1:0] ra;
    logic [`REG_IDX_WIDTH-1:0] rb;      // Literal high bits when is_lit
    logic [2:0]                lit_low;
    logic                      is_lit;
    logic [6:0]                func;
    logic [`REG_IDX_WIDTH-1:0] rc;
  } op_fmt_t;

  // Same 32 bits, view picked by opcode
  typedef union packed {
    mem_fmt_t mem_fmt;
    op_fmt_t  op_fmt;
  } inst_word_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2     // Not driven by the front end
  } bus_cmd_t;

  typedef enum logic [3:0] {
    NO_ERROR          = 4'h0,
    HALTED_ON_HALT    = 4'h2,
    HALTED_ON_ILLEGAL = 4'h3
  } error_status_t;

  typedef enum logic [1:0] {
    REQUEST,
    WAIT,
    DELIVER,
    HALTED
  } fetch_state_t;

endpackage

// File: pipe_settings.svh
// Width, register index, no-op word and opcode macros for the in-order pipeline
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths

// Address and NPC
`define PC_WIDTH        64
`define INST_WIDTH      32
// One memory word carries two instructions
`define MEM_WIDTH       64
`define REG_IDX_WIDTH   5
// Memory tag, 0 means none
`define TAG_WIDTH       4

//////////////////////////////////////////////////
// Registers and reset word

// Never written
`define ZERO_REG        5'd31
// bis $31,$31,$31
`define NOOP_INST       32'h47ff041f

//////////////////////////////////////////////////
// Opcodes

`define OP_WIDTH        6
`define OP_PAL          6'h00
`define OP_INTA         6'h10
`define OP_LDQ          6'h29
`define OP_STQ          6'h2d

// PAL function field, halt is function zero
`define PAL_FUNC_WIDTH  26
`define PAL_HALT        26'h0000000

`endif

// File: pipe_top.sv
// Top level of the fetch, decode and commit pipeline
`timescale 1ns/10ps
`include "pipe_settings.svh"

module pipe_top
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`TAG_WIDTH-1:0]     mem2proc_response,
  input  logic [`TAG_WIDTH-1:0]     mem2proc_tag,
  input  logic [`MEM_WIDTH-1:0]     mem2proc_data,
  output pipe_pkg::bus_cmd_t        proc2mem_command,
  output logic [`PC_WIDTH-1:0]      proc2mem_addr,
  output logic                      commit_valid,
  output logic [`PC_WIDTH-1:0]      commit_npc,
  output logic [`INST_WIDTH-1:0]    commit_ir,
  output logic [`REG_IDX_WIDTH-1:0] commit_wr_idx,
  output logic                      commit_wr_en,
  output pipe_pkg::error_status_t   error_status
);

  // Fetch to decode
  logic                      if_valid;
  logic [`INST_WIDTH-1:0]    if_ir;
  logic [`PC_WIDTH-1:0]      if_npc;

  // Decode to commit
  logic                      id_valid;
  logic [`INST_WIDTH-1:0]    id_ir;
  logic [`PC_WIDTH-1:0]      id_npc;
  logic [`REG_IDX_WIDTH-1:0] id_dest_idx;
  logic                      id_halt;
  logic                      id_illegal;

  logic                      halted;   // Commit back to fetch

  fetch_fsm fetch_i
  (
    .clock(clock),                 .reset(reset),
    .halted(halted),
    .mem2proc_response(mem2proc_response),
    .mem2proc_tag(mem2proc_tag),   .mem2proc_data(mem2proc_data),
    .proc2mem_command(proc2mem_command),
    .proc2mem_addr(proc2mem_addr),
    .if_valid(if_valid),           .if_ir(if_ir),             .if_npc(if_npc)
  );

  decode_stage decode_i
  (
    .clock(clock),                 .reset(reset),
    .if_valid(if_valid),           .if_ir(if_ir),             .if_npc(if_npc),
    .id_valid(id_valid),           .id_ir(id_ir),             .id_npc(id_npc),
    .id_dest_idx(id_dest_idx),     .id_halt(id_halt),         .id_illegal(id_illegal)
  );

  commit_stage commit_i
  (
    .clock(clock),                 .reset(reset),
    .id_valid(id_valid),           .id_ir(id_ir),             .id_npc(id_npc),
    .id_dest_idx(id_dest_idx),     .id_halt(id_halt),         .id_illegal(id_illegal),
    .commit_valid(commit_valid),   .commit_npc(commit_npc),   .commit_ir(commit_ir),
    .commit_wr_idx(commit_wr_idx), .commit_wr_en(commit_wr_en),
    .error_status(error_status),   .halted(halted)
  );

endmodule

// File: tb_pipe_top.sv
// Testbench for pipe_top with clock, memory model, stimulus table, commit checker and watchdog
`timescale 1ns/10ps
`include "pipe_settings.svh"

module tb_pipe_top;

  import pipe_pkg::*;

  localparam int CLOCK_PERIOD = 100;
  localparam int N_ROWS       = 25;
  localparam int N_TESTS      = 6;

  logic                      clock             = 1'b0;
  logic                      reset             = 1'b1;
  logic [`TAG_WIDTH-1:0]     mem2proc_response = '0;
  logic [`TAG_WIDTH-1:0]     mem2proc_tag      = '0;
  logic [`MEM_WIDTH-1:0]     mem2proc_data     = '0;
  bus_cmd_t                  proc2mem_command;
  logic [`PC_WIDTH-1:0]      proc2mem_addr;
  logic                      commit_valid;
  logic [`PC_WIDTH-1:0]      commit_npc;
  logic [`INST_WIDTH-1:0]    commit_ir;
  logic [`REG_IDX_WIDTH-1:0] commit_wr_idx;
  logic                      commit_wr_en;
  error_status_t             error_status;

  // Stimulus table, one row per instruction
  int                        row_test    [N_ROWS];
  logic [`INST_WIDTH-1:0]    row_inst    [N_ROWS];
  logic [`REG_IDX_WIDTH-1:0] row_dest    [N_ROWS];
  logic                      row_wr_en   [N_ROWS];
  error_status_t             row_status  [N_ROWS];
  logic                      row_commits [N_ROWS];   // Zero for words behind a halt
  int                        row_count = 0;

  logic [`INST_WIDTH-1:0]    prog     [$];   // Program image of the current test
  int                        exp_rows [$];
  int                        exp_pos  [$];
  int                        checks = 0;
  int                        errors = 0;

  // Memory model state
  logic                      pending = 1'b0;
  logic [`TAG_WIDTH-1:0]     pend_tag;
  logic [`PC_WIDTH-1:0]      pend_addr;
  logic [`TAG_WIDTH-1:0]     next_tag = 4'd1;
  int                        delay;

  pipe_top dut_i
  (
    .clock(clock),                         .reset(reset),
    .mem2proc_response(mem2proc_response), .mem2proc_tag(mem2proc_tag),
    .mem2proc_data(mem2proc_data),
    .proc2mem_command(proc2mem_command),   .proc2mem_addr(proc2mem_addr),
    .commit_valid(commit_valid),           .commit_npc(commit_npc),
    .commit_ir(commit_ir),                 .commit_wr_idx(commit_wr_idx),
    .commit_wr_en(commit_wr_en),           .error_status(error_status)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  //////////////////////////////////////////////////
  // Instruction encoders

  function automatic logic [31:0] op_inst(input logic [4:0] ra, input logic [4:0] rb,
                                          input logic [4:0] rc, input logic [6:0] func);
    return {`OP_INTA, ra, rb, 3'b000, 1'b0, func, rc};
  endfunction

  function automatic logic [31:0] mem_inst(input logic [5:0] op, input logic [4:0] ra,
                                           input logic [4:0] rb, input logic [15:0] disp);
    return {op, ra, rb, disp};
  endfunction

  function automatic logic [31:0] pal_inst(input logic [25:0] func);
    return {`OP_PAL, func};
  endfunction

  task automatic add_row(input int t, input logic [31:0] inst, input logic [4:0] dest,
                         input logic wr_en, input error_status_t status, input logic commits);
    row_test[row_count]    = t;
    row_inst[row_count]    = inst;
    row_dest[row_count]    = dest;
    row_wr_en[row_count]   = wr_en;
    row_status[row_count]  = status;
    row_commits[row_count] = commits;
    row_count++;
  endtask

  task automatic load_table();
    // Operate format, rc 31 gives no write
    add_row(1, op_inst(5'd1, 5'd2, 5'd3, 7'h20), 5'd3, 1'b1, NO_ERROR, 1'b1);
    add_row(1, op_inst(5'd4, 5'd5, 5'd31, 7'h00), 5'd31, 1'b0, NO_ERROR, 1'b1);
    add_row(1, op_inst(5'd6, 5'd7, 5'd9, 7'h29), 5'd9, 1'b1, NO_ERROR, 1'b1);
    add_row(1, pal_inst(26'h0), 5'd31, 1'b0, HALTED_ON_HALT, 1'b1);
    add_row(1, op_inst(5'd1, 5'd1, 5'd10, 7'h20), 5'd10, 1'b1, NO_ERROR, 1'b0);
    add_row(1, mem_inst(`OP_LDQ, 5'd11, 5'd2, 16'h0010), 5'd11, 1'b1, NO_ERROR, 1'b0);
    // Loads and stores, halt in a high half
    add_row(2, mem_inst(`OP_LDQ, 5'd7, 5'd2, 16'h0008), 5'd7, 1'b1, NO_ERROR, 1'b1);
    add_row(2, mem_inst(`OP_STQ, 5'd8, 5'd2, 16'h0010), 5'd31, 1'b0, NO_ERROR, 1'b1);
    add_row(2, mem_inst(`OP_LDQ, 5'd31, 5'd3, 16'h0000), 5'd31, 1'b0, NO_ERROR, 1'b1);
    add_row(2, mem_inst(`OP_LDQ, 5'd12, 5'd30, 16'hfff8), 5'd12, 1'b1, NO_ERROR, 1'b1);
    add_row(2, mem_inst(`OP_STQ, 5'd12, 5'd30, 16'h0020), 5'd31, 1'b0, NO_ERROR, 1'b1);
    add_row(2, pal_inst(26'h0), 5'd31, 1'b0, HALTED_ON_HALT, 1'b1);
    add_row(2, mem_inst(`OP_LDQ, 5'd13, 5'd2, 16'h0000), 5'd13, 1'b1, NO_ERROR, 1'b0);
    // Branch opcode is illegal here
    add_row(3, op_inst(5'd2, 5'd3, 5'd4, 7'h20), 5'd4, 1'b1, NO_ERROR, 1'b1);
    add_row(3, mem_inst(6'h30, 5'd26, 5'd0, 16'h0004), 5'd31, 1'b0, HALTED_ON_ILLEGAL, 1'b1);
    add_row(3, op_inst(5'd5, 5'd5, 5'd5, 7'h20), 5'd5, 1'b1, NO_ERROR, 1'b0);
    add_row(3, pal_inst(26'h0), 5'd31, 1'b0, HALTED_ON_HALT, 1'b0);
    // Unknown opcode
    add_row(4, mem_inst(`OP_LDQ, 5'd1, 5'd2, 16'h0000), 5'd1, 1'b1, NO_ERROR, 1'b1);
    add_row(4, mem_inst(`OP_STQ, 5'd1, 5'd2, 16'h0008), 5'd31, 1'b0, NO_ERROR, 1'b1);
    add_row(4, 32'h0400_0000, 5'd31, 1'b0, HALTED_ON_ILLEGAL, 1'b1);
    add_row(4, op_inst(5'd3, 5'd4, 5'd8, 7'h20), 5'd8, 1'b1, NO_ERROR, 1'b0);
    // Halt at address 0, then a PAL call that is not halt
    add_row(5, pal_inst(26'h0), 5'd31, 1'b0, HALTED_ON_HALT, 1'b1);
    add_row(5, op_inst(5'd1, 5'd2, 5'd3, 7'h20), 5'd3, 1'b1, NO_ERROR, 1'b0);
    add_row(6, pal_inst(26'h83), 5'd31, 1'b0, HALTED_ON_ILLEGAL, 1'b1);
    add_row(6, op_inst(5'd1, 5'd2, 5'd3, 7'h20), 5'd3, 1'b1, NO_ERROR, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Memory model

  // Program word, or a fill built from the whole address
  function automatic logic [63:0] read_word(input logic [63:0] addr);
    logic [63:0] word;
    int          lo;
    word = addr ^ 64'h9e37_79b9_7f4a_7c15;
    lo   = 2 * int'(addr[15:3]);
    if ((addr[63:16] == '0) && (lo < prog.size()))
      word[31:0] = prog[lo];
    if ((addr[63:16] == '0) && (lo + 1 < prog.size()))
      word[63:32] = prog[lo + 1];
    return word;
  endfunction

  always @(negedge clock)
  begin
    mem2proc_response <= '0;
    mem2proc_tag      <= '0;
    if (reset)
    begin
      pending  = 1'b0;
      next_tag = 4'd1;
    end
    else if (pending)
    begin
      delay = delay - 1;
      if (delay == 0)
      begin
        mem2proc_tag  <= pend_tag;
        mem2proc_data <= read_word(pend_addr);
        pending = 1'b0;
      end
    end
    else if ((proc2mem_command == BUS_LOAD) && (($urandom % 4) != 0))   // 1 in 4 refused
    begin
      mem2proc_response <= next_tag;
      pend_tag  = next_tag;
      pend_addr = proc2mem_addr;
      delay     = 1 + int'($urandom % 4);
      pending   = 1'b1;
      next_tag  = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
  end

  //////////////////////////////////////////////////
  // Checking

  task automatic compare_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic build_image(input int t);
    prog.delete();
    exp_rows.delete();
    exp_pos.delete();
    for (int r = 0; r < row_count; r++)
    begin
      if (row_test[r] == t)
      begin
        if (row_commits[r])
        begin
          exp_rows.push_back(r);
          exp_pos.push_back(prog.size());
        end
        prog.push_back(row_inst[r]);
      end
    end
  endtask

  task automatic reset_dut();
    @(negedge clock);
    reset <= 1'b1;
    repeat (16) @(negedge clock);
    reset <= 1'b0;
    compare_hex("error_status", 64'(error_status), 64'(NO_ERROR));
    compare_hex("commit_valid", 64'(commit_valid), 64'd0);
    compare_hex("commit_wr_en", 64'(commit_wr_en), 64'd0);
    compare_hex("proc2mem_command", 64'(proc2mem_command), 64'(BUS_NONE));
    @(negedge clock);
    compare_hex("proc2mem_command", 64'(proc2mem_command), 64'(BUS_LOAD));   // Fetch restarts
    compare_hex("proc2mem_addr", proc2mem_addr, 64'd0);
  endtask

  task automatic check_commits(output int n);
    int r;
    n = 0;
    while (n < exp_rows.size())
    begin
      @(negedge clock);
      if (commit_valid)
      begin
        r = exp_rows[n];
        compare_hex("commit_npc", commit_npc, 64'(4 * exp_pos[n] + 4));
        compare_hex("commit_ir", 64'(commit_ir), 64'(row_inst[r]));
        compare_hex("commit_wr_idx", 64'(commit_wr_idx), 64'(row_dest[r]));
        compare_hex("commit_wr_en", 64'(commit_wr_en), 64'(row_wr_en[r]));
        compare_hex("error_status", 64'(error_status), 64'(row_status[r]));
        n++;
      end
    end
    // Machine stays stopped behind the halting instruction
    repeat (20)
    begin
      @(negedge clock);
      compare_hex("commit_valid", 64'(commit_valid), 64'd0);
      compare_hex("proc2mem_command", 64'(proc2mem_command), 64'(BUS_NONE));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence and watchdog

  initial
  begin
    int err_before;
    int n;
    void'($urandom(32'hc3c4_9c7e));
    load_table();
    for (int t = 1; t <= N_TESTS; t++)
    begin
      err_before = errors;
      build_image(t);
      reset_dut();
      check_commits(n);
      $display("Test %0d finished: %0d commits, %0d errors", t, n, errors - err_before);
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    #(60 * N_ROWS * CLOCK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", 60 * N_ROWS);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
